/* logic/moesiPkg.sv */
package moesiPkg;

	// Line states of the MOESI protocol. INVALID is the state every line resets to.
	typedef enum logic [2:0] {
		MODIFIED,
		OWNED,
		EXCLUSIVE,
		SHARED,
		INVALID
	} lineState;

	// Commands seen on the snooped bus.
	typedef enum logic [1:0] {
		BUS_NONE,
		BUS_READ,
		BUS_INVALIDATE,
		BUS_READ_EXCLUSIVE
	} busCommand;

endpackage : moesiPkg

/* logic/cachePkg.sv */
package cachePkg;
	import moesiPkg::*;

	localparam int lineCount = 16;
	localparam int indexWidth = $clog2(lineCount);
	localparam int tagWidth = 8;

	typedef logic [indexWidth-1:0] cacheIndex;
	typedef logic [tagWidth-1:0] cacheTag;

	typedef enum logic {
		CPU_ACCESS,
		SNOOP
	} requestKind;

	// A processor access uses read and write, a snoop uses command.
	typedef struct packed {
		requestKind kind;
		cacheTag tag;
		cacheIndex index;
		logic read;
		logic write;
		busCommand command;
	} coherenceRequest;

	typedef struct packed {
		coherenceRequest request;
		logic hit;
		lineState stateOut;
		lineState writeBackState; // Resident line displaced by a processor miss.
	} lookupResult;

	typedef struct packed {
		lineState stateIn;
		logic writeBackRequired;
		logic invalidateRequired;
		logic readExclusiveRequired;
		logic request; // This cache supplies the data.
		logic sharedOut;
	} protocolResult;

	typedef struct packed {
		requestKind kind;
		cacheTag tag;
		cacheIndex index;
		lineState stateIn;
		logic writeBackRequired;
		logic invalidateRequired;
		logic readExclusiveRequired;
		logic request;
		logic sharedOut;
	} coherenceResponse;

	typedef struct packed {
		logic enable;
		cacheIndex index;
		cacheTag tag;
		lineState state;
	} stateWrite;

endpackage : cachePkg

/* logic/requestArbiter.sv */
`timescale 1ns/10ps

module requestArbiter
	import moesiPkg::*;
	import cachePkg::*;
(
	input logic clock,
	input logic reset,
	input logic cpuValid,
	output logic cpuReady,
	input coherenceRequest cpuRequest,
	input logic snoopValid,
	output logic snoopReady,
	input coherenceRequest snoopRequest,
	output logic arbitratedValid,
	input logic arbitratedReady,
	output coherenceRequest arbitrated
);

	logic loadEnable;

	assign loadEnable = !arbitratedValid || arbitratedReady; // Empty or handing its item on.
	assign snoopReady = loadEnable;
	assign cpuReady = loadEnable && !snoopValid; // Snoops always go first.

	always_ff @(posedge clock) begin
		if (reset) begin
			arbitratedValid <= 1'b0;
		end else if (loadEnable) begin
			arbitratedValid <= snoopValid || cpuValid;
		end
	end

	always_ff @(posedge clock) begin
		if (loadEnable) begin
			arbitrated <= snoopValid ? snoopRequest : cpuRequest;
		end
	end

	// A processor access is either a read or a write.
	cpuAccessKind : assert property (@(posedge clock) disable iff (reset)
		cpuValid |-> !(cpuRequest.read && cpuRequest.write));

	snoopCommand : assert property (@(posedge clock) disable iff (reset)
		snoopValid |-> snoopRequest.command != BUS_NONE);

endmodule : requestArbiter

/* logic/stateLookup.sv */
`timescale 1ns/10ps

module stateLookup
	import moesiPkg::*;
	import cachePkg::*;
(
	input logic clock,
	input logic reset,
	input logic arbitratedValid,
	output logic arbitratedReady,
	input coherenceRequest arbitrated,
	output logic lookupValid,
	input logic lookupReady,
	output lookupResult lookup,
	input stateWrite update
);

	cacheTag tagArray [lineCount];
	lineState stateArray [lineCount];

	logic captureForward;
	cacheTag captureTag;
	lineState captureState;

	// Classify a request against the line that is resident at its index.
	function automatic lookupResult evaluate(
		input coherenceRequest request,
		input cacheTag residentTag,
		input lineState residentState
	);
		lookupResult entry;
		entry.request = request;
		entry.hit = residentState != INVALID && residentTag == request.tag;
		entry.stateOut = entry.hit ? residentState : INVALID;
		entry.writeBackState = (request.kind == CPU_ACCESS && !entry.hit) ? residentState : INVALID;
		return entry;
	endfunction

	assign arbitratedReady = !lookupValid || lookupReady;

	// A write landing at this edge is seen by the item captured at the same edge.
	assign captureForward = update.enable && update.index == arbitrated.index;
	assign captureTag = captureForward ? update.tag : tagArray[arbitrated.index];
	assign captureState = captureForward ? update.state : stateArray[arbitrated.index];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < lineCount; i++) begin
				stateArray[i] <= INVALID;
			end
		end else if (update.enable) begin
			stateArray[update.index] <= update.state;
		end
	end

	always_ff @(posedge clock) begin
		if (update.enable) begin
			tagArray[update.index] <= update.tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lookupValid <= 1'b0;
		end else if (arbitratedReady) begin
			lookupValid <= arbitratedValid;
		end
	end

	always_ff @(posedge clock) begin
		if (arbitratedReady && arbitratedValid) begin
			lookup <= evaluate(arbitrated, captureTag, captureState);
		end
	end

	// A line just invalidated by stage three must not hit for the item that follows it.
	invalidatedNoHit : assert property (@(posedge clock) disable iff (reset)
		(update.enable && update.state == INVALID && arbitratedValid && arbitratedReady
			&& arbitrated.index == update.index) |=> !lookup.hit);

endmodule : stateLookup

/* logic/MOESI.sv */
`timescale 1ns/10ps

module MOESI
	import moesiPkg::*;
	import cachePkg::*;
(
	input lookupResult lookup,
	input logic sharedIn,
	output protocolResult result
);

	protocolResult cpuResult;
	protocolResult snoopResult;

	// Processor side.
	always_comb begin
		cpuResult = '0;
		cpuResult.writeBackRequired = lookup.writeBackState == MODIFIED ||
			lookup.writeBackState == OWNED;
		cpuResult.invalidateRequired = lookup.request.write &&
			lookup.stateOut != MODIFIED && lookup.stateOut != EXCLUSIVE;
		cpuResult.readExclusiveRequired = lookup.request.write && lookup.stateOut == INVALID;

		cpuResult.stateIn = lookup.stateOut;
		case (lookup.stateOut)
			MODIFIED: begin
				cpuResult.stateIn = MODIFIED;
			end

			OWNED, EXCLUSIVE, SHARED: begin
				if (lookup.request.write) begin
					cpuResult.stateIn = MODIFIED;
				end
			end

			INVALID: begin
				if (lookup.request.read) begin
					if (sharedIn) begin
						cpuResult.stateIn = SHARED; // Another cache holds a copy.
					end else begin
						cpuResult.stateIn = EXCLUSIVE;
					end
				end else if (lookup.request.write) begin
					cpuResult.stateIn = MODIFIED;
				end
			end

			default: begin
				cpuResult.stateIn = INVALID;
			end
		endcase
	end

	// Snoop side.
	always_comb begin
		snoopResult = '0;
		snoopResult.request = lookup.stateOut == MODIFIED || lookup.stateOut == OWNED ||
			lookup.stateOut == EXCLUSIVE;
		snoopResult.sharedOut = lookup.stateOut != INVALID;

		snoopResult.stateIn = lookup.stateOut;
		case (lookup.request.command)
			BUS_READ: begin
				case (lookup.stateOut)
					MODIFIED: begin
						snoopResult.stateIn = OWNED; // Dirty data stays here, now shared.
					end

					EXCLUSIVE: begin
						snoopResult.stateIn = SHARED;
					end

					default: begin
						snoopResult.stateIn = lookup.stateOut;
					end
				endcase
			end

			BUS_INVALIDATE, BUS_READ_EXCLUSIVE: begin
				snoopResult.stateIn = INVALID;
			end

			default: begin
				snoopResult.stateIn = lookup.stateOut;
			end
		endcase
	end

	assign result = lookup.request.kind == SNOOP ? snoopResult : cpuResult;

endmodule : MOESI

/* logic/stateUpdate.sv */
`timescale 1ns/10ps

module stateUpdate
	import moesiPkg::*;
	import cachePkg::*;
(
	input logic clock,
	input logic reset,
	input logic lookupValid,
	output logic lookupReady,
	input lookupResult lookup,
	input protocolResult result,
	input logic sharedIn,
	output stateWrite update,
	output logic responseValid,
	input logic responseReady,
	output coherenceResponse response
);

	logic accept;

	assign lookupReady = !responseValid || responseReady;
	assign accept = lookupValid && lookupReady;

	// The array is written at the edge the item is taken. A snoop miss leaves it alone.
	always_comb begin
		update.enable = accept && (lookup.request.kind == CPU_ACCESS || lookup.hit);
		update.index = lookup.request.index;
		update.tag = lookup.request.tag;
		update.state = result.stateIn;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			responseValid <= 1'b0;
		end else if (lookupReady) begin
			responseValid <= lookupValid;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			response.kind <= lookup.request.kind;
			response.tag <= lookup.request.tag;
			response.index <= lookup.request.index;
			response.stateIn <= result.stateIn;
			response.writeBackRequired <= result.writeBackRequired;
			response.invalidateRequired <= result.invalidateRequired;
			response.readExclusiveRequired <= result.readExclusiveRequired;
			response.request <= result.request;
			response.sharedOut <= result.sharedOut;
		end
	end

	// Processor requirements and snoop data supply never come from the same item.
	sideExclusive : assert property (@(posedge clock) disable iff (reset)
		responseValid |-> !((response.writeBackRequired || response.invalidateRequired ||
			response.readExclusiveRequired) && response.request));

	// A read fill follows the shared line as it stood at acceptance.
	readFillShared : assert property (@(posedge clock) disable iff (reset)
		(accept && lookup.request.kind == CPU_ACCESS && lookup.request.read &&
			lookup.stateOut == INVALID)
		|=> response.stateIn == ($past(sharedIn) ? SHARED : EXCLUSIVE));

endmodule : stateUpdate

/* logic/coherenceController.sv */
`timescale 1ns/10ps

module coherenceController
	import cachePkg::*;
(
	input logic clock,
	input logic reset,
	input logic cpuValid,
	output logic cpuReady,
	input coherenceRequest cpuRequest,
	input logic snoopValid,
	output logic snoopReady,
	input coherenceRequest snoopRequest,
	input logic sharedIn,
	output logic responseValid,
	input logic responseReady,
	output coherenceResponse response
);

	logic arbitratedValid;
	logic arbitratedReady;
	coherenceRequest arbitrated;
	logic lookupValid;
	logic lookupReady;
	lookupResult lookup;
	protocolResult result;
	stateWrite update;

	requestArbiter arbiter (
		.clock(clock),
		.reset(reset),
		.cpuValid(cpuValid),
		.cpuReady(cpuReady),
		.cpuRequest(cpuRequest),
		.snoopValid(snoopValid),
		.snoopReady(snoopReady),
		.snoopRequest(snoopRequest),
		.arbitratedValid(arbitratedValid),
		.arbitratedReady(arbitratedReady),
		.arbitrated(arbitrated)
	);

	stateLookup lookupStage (
		.clock(clock),
		.reset(reset),
		.arbitratedValid(arbitratedValid),
		.arbitratedReady(arbitratedReady),
		.arbitrated(arbitrated),
		.lookupValid(lookupValid),
		.lookupReady(lookupReady),
		.lookup(lookup),
		.update(update)
	);

	MOESI protocol (
		.lookup(lookup),
		.sharedIn(sharedIn),
		.result(result)
	);

	stateUpdate updateStage (
		.clock(clock),
		.reset(reset),
		.lookupValid(lookupValid),
		.lookupReady(lookupReady),
		.lookup(lookup),
		.result(result),
		.sharedIn(sharedIn),
		.update(update),
		.responseValid(responseValid),
		.responseReady(responseReady),
		.response(response)
	);

endmodule : coherenceController

/* tests/coherenceVectors.svh */
`ifndef COHERENCE_VECTORS_SVH
`define COHERENCE_VECTORS_SVH

// Columns: request, sharedIn, expected next state, expected flags.
// The flags are {writeBack, invalidate, readExclusive, supply, sharedOut}.
typedef struct packed {
	coherenceRequest request;
	logic sharedIn;
	lineState stateIn;
	logic [4:0] flags;
} vectorRow;

localparam int vectorCount = 24;

vectorRow vectors [vectorCount];

task automatic loadVectors();
	vectors[0] = '{cpuAccess(1'b0, 8'hA0, 4'd0), 1'b0, EXCLUSIVE, 5'b00000}; // No other copy.
	vectors[1] = '{cpuAccess(1'b0, 8'hA0, 4'd1), 1'b1, SHARED, 5'b00000};
	vectors[2] = '{cpuAccess(1'b0, 8'hA0, 4'd0), 1'b1, EXCLUSIVE, 5'b00000};
	vectors[3] = '{cpuAccess(1'b0, 8'hA0, 4'd1), 1'b0, SHARED, 5'b00000};
	vectors[4] = '{cpuAccess(1'b1, 8'hA0, 4'd0), 1'b0, MODIFIED, 5'b00000};
	vectors[5] = '{cpuAccess(1'b1, 8'hA0, 4'd1), 1'b0, MODIFIED, 5'b01000};
	vectors[6] = '{cpuAccess(1'b1, 8'hA0, 4'd0), 1'b0, MODIFIED, 5'b00000};
	vectors[7] = '{cpuAccess(1'b1, 8'hA0, 4'd2), 1'b0, MODIFIED, 5'b01100};
	vectors[8] = '{busSnoop(BUS_READ, 8'hA0, 4'd0), 1'b0, OWNED, 5'b00011};
	vectors[9] = '{cpuAccess(1'b1, 8'hA0, 4'd0), 1'b0, MODIFIED, 5'b01000};
	vectors[10] = '{cpuAccess(1'b0, 8'hA0, 4'd3), 1'b0, EXCLUSIVE, 5'b00000};
	vectors[11] = '{busSnoop(BUS_READ, 8'hA0, 4'd3), 1'b0, SHARED, 5'b00011};
	vectors[12] = '{busSnoop(BUS_INVALIDATE, 8'hA0, 4'd3), 1'b0, INVALID, 5'b00001};
	vectors[13] = '{busSnoop(BUS_READ_EXCLUSIVE, 8'hA0, 4'd1), 1'b0, INVALID, 5'b00011};
	vectors[14] = '{busSnoop(BUS_READ, 8'hB0, 4'd2), 1'b0, INVALID, 5'b00000}; // Tag miss.
	vectors[15] = '{busSnoop(BUS_INVALIDATE, 8'hC0, 4'd5), 1'b0, INVALID, 5'b00000};
	vectors[16] = '{busSnoop(BUS_READ, 8'hA0, 4'd2), 1'b0, OWNED, 5'b00011};
	vectors[17] = '{cpuAccess(1'b0, 8'hB0, 4'd2), 1'b0, EXCLUSIVE, 5'b10000}; // Evicts owned.
	vectors[18] = '{cpuAccess(1'b1, 8'hC0, 4'd0), 1'b0, MODIFIED, 5'b11100};
	vectors[19] = '{cpuAccess(1'b0, 8'hA0, 4'd0), 1'b1, SHARED, 5'b10000};
	vectors[20] = '{cpuAccess(1'b1, 8'hB0, 4'd2), 1'b0, MODIFIED, 5'b00000};
	vectors[21] = '{cpuAccess(1'b1, 8'hA0, 4'd3), 1'b0, MODIFIED, 5'b01100};
	vectors[22] = '{cpuAccess(1'b0, 8'hD0, 4'd1), 1'b1, SHARED, 5'b00000};
	vectors[23] = '{busSnoop(BUS_READ, 8'hD0, 4'd1), 1'b0, SHARED, 5'b00001};
endtask

`endif

/* tests/coherenceControllerTb.sv */
`timescale 1ns/10ps

module coherenceControllerTb
	import moesiPkg::*;
	import cachePkg::*;
();

	logic clock;
	logic reset;
	logic cpuValid;
	logic cpuReady;
	coherenceRequest cpuRequest;
	logic snoopValid;
	logic snoopReady;
	coherenceRequest snoopRequest;
	logic sharedIn;
	logic responseValid;
	logic responseReady;
	coherenceResponse response;

	cacheTag shadowTag [lineCount];
	lineState shadowState [lineCount];
	coherenceResponse expectedQueue [$];
	int responseCount = 0;
	int cycleCount = 0;

	function automatic coherenceRequest cpuAccess(input logic write, input cacheTag tag,
		input cacheIndex index);
		return '{CPU_ACCESS, tag, index, !write, write, BUS_NONE};
	endfunction

	function automatic coherenceRequest busSnoop(input busCommand command, input cacheTag tag,
		input cacheIndex index);
		return '{SNOOP, tag, index, 1'b0, 1'b0, command};
	endfunction

	`include "coherenceVectors.svh"

	localparam int cpuStreamCount = 32;
	localparam int snoopStreamCount = 16;
	localparam int streamCount = cpuStreamCount + snoopStreamCount;
	localparam int timeoutLimit = 4 * vectorCount + streamCount + 100;

	coherenceController UUT (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
			$display("Test FAILED");
			$fatal(1, "Mismatch on %s.", name);
		end
	endtask

	task automatic compareResponse(input coherenceResponse actual,
		input coherenceResponse expected);
		checkValue("response.kind", 32'(actual.kind), 32'(expected.kind));
		checkValue("response.tag", 32'(actual.tag), 32'(expected.tag));
		checkValue("response.index", 32'(actual.index), 32'(expected.index));
		checkValue("response.stateIn", 32'(actual.stateIn), 32'(expected.stateIn));
		checkValue("response.writeBackRequired", 32'(actual.writeBackRequired),
			32'(expected.writeBackRequired));
		checkValue("response.invalidateRequired", 32'(actual.invalidateRequired),
			32'(expected.invalidateRequired));
		checkValue("response.readExclusiveRequired", 32'(actual.readExclusiveRequired),
			32'(expected.readExclusiveRequired));
		checkValue("response.request", 32'(actual.request), 32'(expected.request));
		checkValue("response.sharedOut", 32'(actual.sharedOut), 32'(expected.sharedOut));
	endtask

	// Shadow cache, applied in acceptance order.
	task automatic predict(input coherenceRequest request, input logic shared,
		output coherenceResponse expected);
		lineState resident;
		lineState current;
		logic hit;
		resident = shadowState[request.index];
		hit = resident != INVALID && shadowTag[request.index] == request.tag;
		current = hit ? resident : INVALID; // A miss is handled as if from INVALID.
		expected = '0;
		expected.kind = request.kind;
		expected.tag = request.tag;
		expected.index = request.index;
		if (request.kind == CPU_ACCESS) begin
			expected.writeBackRequired = !hit && (resident == MODIFIED || resident == OWNED);
			expected.invalidateRequired = request.write && current != MODIFIED
				&& current != EXCLUSIVE;
			expected.readExclusiveRequired = request.write && current == INVALID;
			expected.stateIn = request.write ? MODIFIED : current != INVALID ? current
				: shared ? SHARED : EXCLUSIVE;
		end else begin
			expected.request = current == MODIFIED || current == OWNED || current == EXCLUSIVE;
			expected.sharedOut = current != INVALID;
			expected.stateIn = request.command != BUS_READ ? INVALID : current == MODIFIED ? OWNED
				: current == EXCLUSIVE ? SHARED : current;
		end
		if (request.kind == CPU_ACCESS || hit) begin
			shadowState[request.index] = expected.stateIn;
			shadowTag[request.index] = request.tag;
		end
	endtask

	always @(posedge clock) begin
		coherenceResponse expected;
		if (reset) begin
			for (int i = 0; i < lineCount; i++) begin
				shadowState[i] = INVALID;
				shadowTag[i] = '0;
			end
		end else begin
			if (snoopValid) begin
				checkValue("cpuReady", 32'(cpuReady), 32'h0); // A pending snoop goes first.
			end
			if (snoopValid && snoopReady) begin
				predict(snoopRequest, sharedIn, expected);
				expectedQueue.push_back(expected);
			end else if (cpuValid && cpuReady) begin
				predict(cpuRequest, sharedIn, expected);
				expectedQueue.push_back(expected);
			end
			if (responseValid && responseReady) begin
				if (expectedQueue.size() == 0) begin
					$display("A response came out with no request outstanding.");
					$display("Test FAILED");
					$fatal(1, "Unexpected response.");
				end else begin
					compareResponse(response, expectedQueue.pop_front());
					responseCount++;
				end
			end
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount > timeoutLimit) begin
			$display("Timeout: the run did not finish within %0d cycles.", timeoutLimit);
			$display("Test FAILED");
			$fatal(1, "Timeout.");
		end
	end

	// One request at a time, with sharedIn held until its response.
	task automatic applyRow(input vectorRow row);
		coherenceResponse expected;
		expected = {row.request.kind, row.request.tag, row.request.index, row.stateIn, row.flags};
		sharedIn <= row.sharedIn;
		if (row.request.kind == SNOOP) begin
			snoopValid <= 1'b1;
			snoopRequest <= row.request;
		end else begin
			cpuValid <= 1'b1;
			cpuRequest <= row.request;
		end
		@(posedge clock);
		while (!(snoopValid && snoopReady) && !(cpuValid && cpuReady)) @(posedge clock);
		snoopValid <= 1'b0;
		cpuValid <= 1'b0;
		@(posedge clock);
		while (!(responseValid && responseReady)) @(posedge clock);
		compareResponse(response, expected);
	endtask

	function automatic coherenceRequest streamCpuRequest(input int i);
		cacheTag tag;
		tag = ((i / 5) % 2) != 0 ? 8'hB0 : 8'hA0;
		return cpuAccess(i % 3 == 0, tag, cacheIndex'(i % 4));
	endfunction

	function automatic coherenceRequest streamSnoopRequest(input int j);
		cacheTag tag;
		busCommand command;
		tag = ((j / 3) % 2) != 0 ? 8'hB0 : 8'hA0;
		command = j % 4 == 2 ? BUS_INVALIDATE : j % 4 == 3 ? BUS_READ_EXCLUSIVE : BUS_READ;
		return busSnoop(command, tag, cacheIndex'((j / 2) % 4));
	endfunction

	task automatic driveCpuStream();
		int i;
		i = 0;
		while (i < cpuStreamCount) begin
			cpuValid <= 1'b1;
			cpuRequest <= streamCpuRequest(i);
			@(posedge clock);
			if (cpuValid && cpuReady) i++;
		end
		cpuValid <= 1'b0;
	endtask

	task automatic driveSnoopStream();
		int j;
		j = 0;
		while (j < snoopStreamCount) begin
			snoopValid <= 1'b1;
			snoopRequest <= streamSnoopRequest(j);
			@(posedge clock);
			if (snoopValid && snoopReady) begin
				j++;
				snoopValid <= 1'b0;
				repeat (2) @(posedge clock); // Lets processor accesses through between snoops.
			end
		end
	endtask

	task automatic driveBackPressure();
		while (responseCount < vectorCount + streamCount) begin
			responseReady <= ($urandom % 4) != 0;
			@(posedge clock);
		end
		responseReady <= 1'b1;
	endtask

	initial begin
		void'($urandom(32'h8f53e41d));
		loadVectors();
		reset <= 1'b1;
		cpuValid <= 1'b0;
		cpuRequest <= '0;
		snoopValid <= 1'b0;
		snoopRequest <= '0;
		sharedIn <= 1'b0;
		responseReady <= 1'b1;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < vectorCount; i++) begin
			applyRow(vectors[i]);
		end
		sharedIn <= 1'b0;
		fork
			driveCpuStream();
			driveSnoopStream();
			driveBackPressure();
		join
		repeat (4) @(posedge clock);
		if (expectedQueue.size() != 0 || responseCount != vectorCount + streamCount) begin
			$display("Run ended with %0d responses and %0d still outstanding.", responseCount,
				expectedQueue.size());
			$display("Test FAILED");
			$fatal(1, "Responses were lost.");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule : coherenceControllerTb

/* sim.f */
+incdir+tests
logic/moesiPkg.sv
logic/cachePkg.sv
logic/requestArbiter.sv
logic/stateLookup.sv
logic/MOESI.sv
logic/stateUpdate.sv
logic/coherenceController.sv
tests/coherenceControllerTb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sim.f \
		--top-module coherenceControllerTb -Mdir obj_dir
	./obj_dir/VcoherenceControllerTb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
